/* compile.f */
+incdir+hdl
hdl/flitPkg.sv
hdl/arbPkg.sv
hdl/grantTimer.sv
hdl/outputArbiter.sv
hdl/outputCrossbar.sv
hdl/routerOutputPort.sv
test/tbRouterOutputPort.sv

/* hdl/arbPkg.sv */
`include "router_defs.svh"

package arbPkg;

  // Bit 0 = L, 1 = N, 2 = E, 3 = W, 4 = S.
  typedef logic [`NUM_PORTS-1:0] portMask_t;

  // Index of one input in the same order as portMask_t.
  typedef logic [2:0] portIdx_t;

  // ##################################################
  // Arbiter state
  // ##################################################

  // One-hot, with bit 0 as the idle state and bits 5..1 as the
  // grant states, so the grant mask is the upper five bits.
  typedef enum logic [5:0]
  {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState_t;

endpackage

/* hdl/flitPkg.sv */
`include "router_defs.svh"

package flitPkg;

  // ##################################################
  // Flit fields
  // ##################################################

  // Header, body or tail marker.
  typedef logic [`FLIT_ID_W-1:0] flitId_t;

  // Number of cycles an input may hold the output once granted.
  typedef logic [`LEN_W-1:0] pktLength_t;

  typedef logic [`FLIT_DATA_W-1:0] flitData_t;

  // ##################################################
  // Flit and flit bus
  // ##################################################

  // One flit as seen on a router link, 48 bits in all.
  typedef struct packed
  {
    logic       valid;
    flitId_t    id;
    pktLength_t length;
    flitData_t  data;
  } flit_t;

  // One flit per input, indexed L, N, E, W, S from 0.
  typedef flit_t [`NUM_PORTS-1:0] flitBus_t;

endpackage

/* hdl/grantTimer.sv */
`timescale 1ns/10ps

`include "router_defs.svh"

module grantTimer
  import flitPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t inFlit,
  input  logic  run,
  output logic  timesUp
);

  pktLength_t lenReg;
  pktLength_t count;
  logic       isHeader;

  assign isHeader = inFlit.valid && (inFlit.id == flitId_t'(`FLIT_HEADER));

  // The length of the latest header is kept until the next header arrives.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenReg <= '0;
      count  <= '0;
    end
    else
    begin
      if (isHeader)
        lenReg <= inFlit.length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == lenReg);

  // The arbiter drops run as soon as timesUp is seen, so the count stops at the length.
  assert property (@(posedge clk) disable iff (rst)
    run |-> (count <= lenReg))
    else $error("grantTimer count %0d passed length %0d", count, lenReg);

endmodule

/* hdl/outputArbiter.sv */
`timescale 1ns/10ps

`include "router_defs.svh"

module outputArbiter
  import flitPkg::*, arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitBus_t  inFlits,
  input  portMask_t reqs,
  output portMask_t grant
);

  arbState_t  state;
  arbState_t  nextState;
  portMask_t  run;
  portMask_t  timesUp;
  portIdx_t   holder;
  portIdx_t   firstIdx;
  logic [2:0] scanLen;
  logic [3:0] cand;
  logic       hold;
  logic       found;

  function automatic arbState_t grantState(portIdx_t idx);
    return arbState_t'(6'b000010 << idx);
  endfunction

  // ##################################################
  // Grant timers, one per input
  // ##################################################

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genTimer
    grantTimer u_grantTimer
    (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlits[i]),
      .run     (run[i]),
      .timesUp (timesUp[i])
    );
  end

  // ##################################################
  // State register and next-state logic
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  assign grant = state[`NUM_PORTS:1];

  // Index of the current holder; meaningless in IDLE.
  always_comb
  begin
    holder = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i])
        holder = portIdx_t'(i);
    end
  end

  assign hold = (state != IDLE) && reqs[holder] && !timesUp[holder];

  // From IDLE all five inputs are scanned starting at L.
  // From a grant state the scan starts after the holder and skips it.
  always_comb
  begin
    if (state == IDLE)
    begin
      firstIdx = '0;
      scanLen  = 3'd5;
    end
    else
    begin
      firstIdx = (holder == portIdx_t'(`NUM_PORTS - 1)) ? '0 : holder + 1'b1;
      scanLen  = 3'd4;
    end
  end

  always_comb
  begin
    run       = '0;
    nextState = IDLE;
    found     = 1'b0;
    cand      = '0;
    if (hold)
    begin
      run[holder] = 1'b1;
      nextState   = state;
    end
    else
    begin
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        cand = {1'b0, firstIdx} + 4'(k);
        if (cand >= 4'(`NUM_PORTS))
          cand = cand - 4'(`NUM_PORTS);
        if (!found && (3'(k) < scanLen) && reqs[cand[2:0]])
        begin
          found     = 1'b1;
          nextState = grantState(cand[2:0]);
        end
      end
    end
  end

  // ##################################################
  // Checks
  // ##################################################

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("outputArbiter grant not one-hot: %b", grant);

  assert property (@(posedge clk) disable iff (rst)
    state inside {IDLE, GRANT_L, GRANT_N, GRANT_E, GRANT_W, GRANT_S})
    else $error("outputArbiter illegal state %b", state);

endmodule

/* hdl/outputCrossbar.sv */
`timescale 1ns/10ps

`include "router_defs.svh"

module outputCrossbar
  import flitPkg::*, arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitBus_t  inFlits,
  input  portMask_t grant,
  output flit_t     outFlit
);

  flit_t selFlit;
  logic  selValid;

  // ##################################################
  // Five-to-one select
  // ##################################################

  // Grant is one-hot or empty, so at most one input is picked.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i])
        selFlit = inFlits[i];
    end
  end

  // Flits on inputs without grant are dropped here.
  assign selValid = (|grant) && selFlit.valid;

  // ##################################################
  // Output register
  // ##################################################

  always_ff @(posedge clk)
  begin
    outFlit.id     <= selFlit.id;
    outFlit.length <= selFlit.length;
    outFlit.data   <= selFlit.data;
    if (rst)
      outFlit.valid <= 1'b0;
    else
      outFlit.valid <= selValid;
  end

  // A forwarded flit must come from the one input that held the grant.
  assert property (@(posedge clk) disable iff (rst)
    outFlit.valid |-> $past($onehot(grant)))
    else $error("outputCrossbar forwarded a flit without a single grant");

endmodule

/* hdl/routerOutputPort.sv */
`timescale 1ns/10ps

module routerOutputPort
  import flitPkg::*, arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitBus_t  inFlits,
  input  portMask_t reqs,
  output portMask_t grant,
  output flit_t     outFlit
);

  // ##################################################
  // Arbitration
  // ##################################################

  // The arbiter's registered grant feeds both the crossbar and the port output.
  outputArbiter u_outputArbiter
  (
    .clk     (clk),
    .rst     (rst),
    .inFlits (inFlits),
    .reqs    (reqs),
    .grant   (grant)
  );

  // ##################################################
  // Datapath
  // ##################################################

  outputCrossbar u_outputCrossbar
  (
    .clk     (clk),
    .rst     (rst),
    .inFlits (inFlits),
    .grant   (grant),
    .outFlit (outFlit)
  );

endmodule

/* hdl/router_defs.svh */
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// ##################################################
// Router geometry
// ##################################################

// Inputs of one mesh output port: L, N, E, W, S.
`define NUM_PORTS 5

// ##################################################
// Flit format
// ##################################################

`define FLIT_DATA_W 32
`define LEN_W 12
`define FLIT_ID_W 3

// Flit id carried by the first flit of a packet.
`define FLIT_HEADER 1

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tbRouterOutputPort -o simTb
./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation FAILED" sim.log
then
  exit 1
fi
grep -q "Simulation PASSED" sim.log

/* test/tbRouterOutputPort.sv */
`timescale 1ns/10ps

`include "router_defs.svh"

module tbRouterOutputPort
  import flitPkg::*, arbPkg::*;
();

  // The tests run for about 150 cycles, so this limit leaves a wide margin.
  localparam int TimeoutCycles = 3000;

  logic        clk;
  logic        rst;
  flitBus_t    inFlits;
  portMask_t   reqs;
  portMask_t   grant;
  flit_t       outFlit;
  string       testName;
  logic [31:0] rngState;
  int          cycleCount;

  // Reference model state.
  logic        refBusy;
  portIdx_t    refHolder;
  pktLength_t  refLen [`NUM_PORTS];
  pktLength_t  refCount [`NUM_PORTS];
  flit_t       refFlit;

  routerOutputPort u_routerOutputPort
  (
    .clk     (clk),
    .rst     (rst),
    .inFlits (inFlits),
    .reqs    (reqs),
    .grant   (grant),
    .outFlit (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  // ##################################################
  // Helpers
  // ##################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic flit_t makeFlit(flitId_t id, pktLength_t length, flitData_t data);
    flit_t f;
    f.valid  = 1'b1;
    f.id     = id;
    f.length = length;
    f.data   = data;
    return f;
  endfunction

  // Body flits never touch the latched lengths.
  task automatic randomBodyFlit(output flit_t f);
    rngState = xorshift32(rngState);
    f = makeFlit(flitId_t'(2), pktLength_t'(rngState[31:20]), flitData_t'(rngState));
  endtask

  function automatic portMask_t modelGrant();
    return refBusy ? (portMask_t'(1) << refHolder) : '0;
  endfunction

  task automatic checkGrant(string name, portMask_t expected, portMask_t actual);
    if (expected !== actual)
    begin
      $display("ERR %s: grant expected %b, actual %b", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "grant mismatch");
    end
  endtask

  // Payload fields are only meaningful when the flit is valid.
  task automatic checkFlit(string name, flit_t expected, flit_t actual);
    if ((expected.valid !== actual.valid) || (expected.valid && (expected !== actual)))
    begin
      $display("ERR %s: outFlit expected %h, actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "flit mismatch");
    end
  endtask

  task automatic expectGrantFor(portMask_t mask, int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      checkGrant(testName, mask, grant);
      @(posedge clk);
    end
  endtask

  task automatic waitIdle();
    @(negedge clk);
    while (grant != '0)
      @(negedge clk);
  endtask

  // ##################################################
  // Reference model of the arbiter, timers and crossbar
  // ##################################################

  always @(posedge clk)
  begin : refModel
    logic     holdNow;
    logic     nextBusy;
    portIdx_t nextHolder;
    portIdx_t idx;
    int       first;
    int       span;
    if (rst)
    begin
      refBusy   = 1'b0;
      refHolder = '0;
      refFlit   = '0;
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        refLen[i]   = '0;
        refCount[i] = '0;
      end
    end
    else
    begin
      if (refBusy && inFlits[refHolder].valid)
        refFlit = inFlits[refHolder];
      else
        refFlit = '0;
      holdNow    = refBusy && reqs[refHolder] && (refCount[refHolder] != refLen[refHolder]);
      nextBusy   = holdNow;
      nextHolder = refHolder;
      if (!holdNow)
      begin
        // The scan starts after the holder and leaves the holder out.
        first = refBusy ? int'(refHolder) + 1 : 0;
        span  = refBusy ? `NUM_PORTS - 1 : `NUM_PORTS;
        for (int k = 0; k < span; k++)
        begin
          idx = portIdx_t'((first + k) % `NUM_PORTS);
          if (!nextBusy && reqs[idx])
          begin
            nextBusy   = 1'b1;
            nextHolder = idx;
          end
        end
      end
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        if (holdNow && (portIdx_t'(i) == refHolder))
          refCount[i] = refCount[i] + 1'b1;
        else
          refCount[i] = '0;
        if (inFlits[i].valid && (inFlits[i].id == flitId_t'(`FLIT_HEADER)))
          refLen[i] = inFlits[i].length;
      end
      refBusy   = nextBusy;
      refHolder = nextHolder;
    end
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkGrant({testName, " (model)"}, modelGrant(), grant);
      checkFlit({testName, " (model)"}, refFlit, outFlit);
    end
  end

  // ##################################################
  // Directed tests
  // ##################################################

  task automatic resetIdle();
    testName = "reset";
    repeat (5)
    begin
      @(negedge clk);
      checkGrant(testName, '0, grant);
      checkFlit(testName, '0, outFlit);
    end
  endtask

  task automatic fixedPriority();
    testName = "priority";
    @(posedge clk);
    reqs <= 5'b10110;
    @(posedge clk);
    expectGrantFor(5'b00010, 1);
    reqs <= '0;
    waitIdle();
    @(posedge clk);
    reqs <= 5'b11000;
    @(posedge clk);
    expectGrantFor(5'b01000, 1);
    reqs <= '0;
    waitIdle();
  endtask

  task automatic lengthHold();
    testName = "hold";
    @(posedge clk);
    inFlits[2] <= makeFlit(flitId_t'(`FLIT_HEADER), 12'd4, '0);
    reqs       <= 5'b01100;
    @(posedge clk);
    inFlits <= '0;
    expectGrantFor(5'b00100, 5);
    expectGrantFor(5'b01000, 1);
    reqs <= '0;
    waitIdle();
  endtask

  task automatic rotationFairness();
    testName = "rotation";
    @(posedge clk);
    for (int p = 0; p < `NUM_PORTS; p++)
      inFlits[p] <= makeFlit(flitId_t'(`FLIT_HEADER), 12'd2, '0);
    reqs <= '1;
    @(posedge clk);
    inFlits <= '0;
    for (int k = 0; k < 6; k++)
      expectGrantFor(portMask_t'(1) << (k % `NUM_PORTS), 3);
    reqs <= '0;
    waitIdle();
    // A lone requester sees one idle cycle between its grants.
    @(posedge clk);
    reqs <= 5'b00010;
    @(posedge clk);
    expectGrantFor(5'b00010, 3);
    expectGrantFor(5'b00000, 1);
    expectGrantFor(5'b00010, 1);
    reqs <= '0;
    waitIdle();
  endtask

  task automatic earlyRelease();
    testName = "early release";
    @(posedge clk);
    inFlits[0] <= makeFlit(flitId_t'(`FLIT_HEADER), 12'd10, '0);
    inFlits[2] <= makeFlit(flitId_t'(`FLIT_HEADER), 12'd10, '0);
    reqs       <= 5'b00101;
    @(posedge clk);
    inFlits <= '0;
    expectGrantFor(5'b00001, 3);
    reqs <= 5'b00100;
    expectGrantFor(5'b00001, 1);
    expectGrantFor(5'b00100, 2);
    reqs <= '0;
    waitIdle();
    // A full hold afterwards shows that the L timer was cleared.
    @(posedge clk);
    reqs <= 5'b00001;
    @(posedge clk);
    expectGrantFor(5'b00001, 11);
    expectGrantFor(5'b00000, 1);
    reqs <= '0;
    waitIdle();
  endtask

  task automatic crossbarForwarding();
    flit_t cur;
    flit_t prev;
    flit_t other;
    testName = "forwarding";
    prev = '0;
    @(posedge clk);
    inFlits[3] <= makeFlit(flitId_t'(`FLIT_HEADER), 12'd20, '0);
    reqs       <= 5'b01000;
    for (int i = 0; i < 12; i++)
    begin
      @(posedge clk);
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        randomBodyFlit(other);
        inFlits[p] <= other;
      end
      randomBodyFlit(cur);
      inFlits[3] <= cur;
      @(negedge clk);
      checkFlit(testName, prev, outFlit);
      prev = cur;
    end
    @(posedge clk);
    inFlits <= '0;
    reqs    <= '0;
    @(negedge clk);
    checkFlit(testName, prev, outFlit);
    waitIdle();
    // With no grant every flit is dropped.
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        randomBodyFlit(other);
        inFlits[p] <= other;
      end
      @(negedge clk);
      checkFlit(testName, '0, outFlit);
    end
    @(posedge clk);
    inFlits <= '0;
    @(negedge clk);
    checkFlit(testName, '0, outFlit);
  endtask

  initial
  begin
    rst        = 1'b1;
    reqs       = '0;
    inFlits    = '0;
    cycleCount = 0;
    testName   = "reset";
    rngState   = 32'h027118d8;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    resetIdle();
    fixedPriority();
    lengthHold();
    rotationFairness();
    earlyRelease();
    crossbarForwarding();
    repeat (2) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
